// ==== rtl/chip_io_pkg.sv ====
////////////////////
// Pad counts, pad vector types, JTAG pin map,
// tie-off patterns and strap timing
////////////////////
`default_nettype none

package chip_io_pkg;

  ////////////////////
  // Pad counts and vectors
  ////////////////////

  localparam int NMioPads = 20;  // Multiplexed pads
  localparam int NDioPads = 15;  // Dedicated pads

  typedef logic [NMioPads-1:0] mio_t;
  typedef logic [NDioPads-1:0] dio_t;

  ////////////////////
  // Pin map
  ////////////////////

  // Straps on MIO
  localparam int MioJtagEnIdx    = 16;  // JTAG=1, SPI=0
  localparam int MioBootstrapIdx = 17;  // Bootstrap=1

  // JTAG resets ride on MIO
  localparam int MioTrstIdx = 18;
  localparam int MioSrstIdx = 19;

  // SPI device pins shared with JTAG
  localparam int DioSckIdx = 14;  // SCK / TCK
  localparam int DioCsbIdx = 13;  // CSB / TMS
  localparam int DioSdiIdx = 12;  // SDI / TDI
  localparam int DioSdoIdx = 11;  // SDO / TDO

  // Pins taken over by the JTAG overlay
  localparam mio_t MioJtagMask = (mio_t'(1) << MioTrstIdx) |
                                 (mio_t'(1) << MioSrstIdx);
  localparam dio_t DioJtagInMask = (dio_t'(1) << DioSckIdx) |
                                   (dio_t'(1) << DioCsbIdx) |
                                   (dio_t'(1) << DioSdiIdx);
  localparam dio_t DioJtagMask = DioJtagInMask | (dio_t'(1) << DioSdoIdx);

  ////////////////////
  // Tie-off values
  ////////////////////

  // SPI CSB is active low, so it idles high toward the core
  localparam dio_t DioTieOff = dio_t'(1) << DioCsbIdx;
  localparam mio_t MioTieOff = '0;  // TRST_N and SRST_N seen low

  ////////////////////
  // Timing
  ////////////////////

  localparam int StrapDelay  = 4;  // Cycles after reset release
  localparam int StrapCntW   = $clog2(StrapDelay + 1);
  localparam int SyncLatency = 4;  // Stable pad change to filtered output

endpackage : chip_io_pkg

`default_nettype wire

// ==== rtl/pad_sync.sv ====
////////////////////
// Two-flop synchronizer with a stability
// filter, generic over the payload type
////////////////////
`timescale 1ns/10ps
`default_nettype none

module pad_sync #(
  parameter type data_t = logic
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  data_t pad_i,   // Raw pad levels
  output data_t sync_o   // Synchronized and filtered
);

  ////////////////////
  // Synchronizer
  ////////////////////

  data_t sync_q1;   // First stage, may go metastable
  data_t sync_q2;   // Second stage, safe to use
  data_t sample_q;  // One cycle older copy of sync_q2

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q1  <= '0;
      sync_q2  <= '0;
      sample_q <= '0;
    end else begin
      sync_q1  <= pad_i;
      sync_q2  <= sync_q1;
      sample_q <= sync_q2;
    end
  end

  ////////////////////
  // Glitch filter
  ////////////////////

  // A level has to be seen on two consecutive edges before it is taken.
  // A single cycle pulse never sits in both sync_q2 and sample_q at once,
  // so it is dropped. A change held stable shows up after the 4th edge.
  logic  stable;
  data_t filt_q;

  assign stable = (sync_q2 == sample_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      filt_q <= '0;
    end else if (stable) begin
      filt_q <= sync_q2;  // Hold otherwise
    end
  end

  assign sync_o = filt_q;

endmodule : pad_sync

`default_nettype wire

// ==== rtl/jtag_overlay.sv ====
////////////////////
// Strap latch and JTAG overlay mux between
// the core side and the pad side
////////////////////
`timescale 1ns/10ps
`default_nettype none

module jtag_overlay (
  input  logic              clk_i,
  input  logic              rst_n_i,

  // Synchronized pad inputs
  input  chip_io_pkg::mio_t mio_sync_i,
  input  chip_io_pkg::dio_t dio_sync_i,

  // Core side
  input  chip_io_pkg::mio_t mio_out_core_i,
  input  chip_io_pkg::mio_t mio_oe_core_i,
  input  chip_io_pkg::dio_t dio_out_core_i,
  input  chip_io_pkg::dio_t dio_oe_core_i,
  output chip_io_pkg::mio_t mio_in_core_o,
  output chip_io_pkg::dio_t dio_in_core_o,

  // Pad side
  output chip_io_pkg::mio_t mio_pad_out_o,
  output chip_io_pkg::mio_t mio_pad_oe_o,
  output chip_io_pkg::dio_t dio_pad_out_o,
  output chip_io_pkg::dio_t dio_pad_oe_o,

  // To JTAG inside core
  output logic              jtag_tck_o,
  output logic              jtag_tms_o,
  output logic              jtag_tdi_o,
  output logic              jtag_trst_no,
  output logic              jtag_srst_no,
  input  logic              jtag_tdo_i,

  // Straps
  output logic              strap_valid_o,
  output logic              bootstrap_o
);

  import chip_io_pkg::*;

  ////////////////////
  // Strap sampling
  ////////////////////

  logic [StrapCntW-1:0] strap_cnt_q;
  logic                 strap_done;
  logic                 strap_latch;
  logic                 strap_valid_q;
  logic                 jtag_en_q;
  logic                 bootstrap_q;

  // Strap pins are driven during reset. Once StrapDelay cycles have
  // passed they have cleared the synchronizer and filter, and they are
  // taken on the following edge.
  assign strap_done  = (strap_cnt_q == StrapCntW'(StrapDelay));
  assign strap_latch = strap_done & ~strap_valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      strap_cnt_q <= '0;
    end else if (!strap_done) begin
      strap_cnt_q <= strap_cnt_q + 1'b1;  // Stops at StrapDelay
    end
  end

  // Sampled once, held until the next reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      strap_valid_q <= 1'b0;
      jtag_en_q     <= 1'b0;
      bootstrap_q   <= 1'b0;
    end else if (strap_latch) begin
      strap_valid_q <= 1'b1;
      jtag_en_q     <= mio_sync_i[MioJtagEnIdx];
      bootstrap_q   <= mio_sync_i[MioBootstrapIdx];
    end
  end

  assign strap_valid_o = strap_valid_q;
  assign bootstrap_o   = bootstrap_q;

  ////////////////////
  // JTAG signals
  ////////////////////

  // Inactive until JTAG mode is latched, TAP held in reset
  assign jtag_tck_o   = jtag_en_q & dio_sync_i[DioSckIdx];
  assign jtag_tms_o   = jtag_en_q & dio_sync_i[DioCsbIdx];
  assign jtag_tdi_o   = jtag_en_q & dio_sync_i[DioSdiIdx];
  assign jtag_trst_no = jtag_en_q & mio_sync_i[MioTrstIdx];
  assign jtag_srst_no = ~jtag_en_q | mio_sync_i[MioSrstIdx];  // Released by default

  ////////////////////
  // Core side inputs
  ////////////////////

  // The core sees fixed tie-offs on the pins that JTAG owns
  always_comb begin
    mio_in_core_o = mio_sync_i;
    dio_in_core_o = dio_sync_i;
    if (jtag_en_q) begin
      mio_in_core_o = (mio_sync_i & ~MioJtagMask) | (MioTieOff & MioJtagMask);
      dio_in_core_o = (dio_sync_i & ~DioJtagMask) | (DioTieOff & DioJtagMask);
    end
  end

  ////////////////////
  // Pad side outputs
  ////////////////////

  // MIO resets are inputs in JTAG mode, so their drivers are turned off
  always_comb begin
    mio_pad_out_o = mio_out_core_i;
    mio_pad_oe_o  = mio_oe_core_i;
    if (jtag_en_q) begin
      mio_pad_oe_o = mio_oe_core_i & ~MioJtagMask;
    end
  end

  // TDO drives the SDO pad, TCK/TMS/TDI pads stay undriven
  always_comb begin
    dio_pad_out_o = dio_out_core_i;
    dio_pad_oe_o  = dio_oe_core_i;
    if (jtag_en_q) begin
      dio_pad_oe_o             = dio_oe_core_i & ~DioJtagInMask;
      dio_pad_out_o[DioSdoIdx] = jtag_tdo_i;
      dio_pad_oe_o[DioSdoIdx]  = 1'b1;
    end
  end

endmodule : jtag_overlay

`default_nettype wire

// ==== rtl/chip_io_top.sv ====
////////////////////
// Pad-side IO subsystem, synchronizers
// for MIO and DIO plus the JTAG overlay
////////////////////
`timescale 1ns/10ps
`default_nettype none

module chip_io_top (
  input  logic              clk_i,
  input  logic              rst_n_i,

  // Pad side
  input  chip_io_pkg::mio_t mio_pad_in_i,
  input  chip_io_pkg::dio_t dio_pad_in_i,
  output chip_io_pkg::mio_t mio_pad_out_o,
  output chip_io_pkg::mio_t mio_pad_oe_o,
  output chip_io_pkg::dio_t dio_pad_out_o,
  output chip_io_pkg::dio_t dio_pad_oe_o,

  // Core side
  input  chip_io_pkg::mio_t mio_out_core_i,
  input  chip_io_pkg::mio_t mio_oe_core_i,
  input  chip_io_pkg::dio_t dio_out_core_i,
  input  chip_io_pkg::dio_t dio_oe_core_i,
  output chip_io_pkg::mio_t mio_in_core_o,
  output chip_io_pkg::dio_t dio_in_core_o,

  // JTAG
  output logic              jtag_tck_o,
  output logic              jtag_tms_o,
  output logic              jtag_tdi_o,
  output logic              jtag_trst_no,
  output logic              jtag_srst_no,
  input  logic              jtag_tdo_i,

  // Straps
  output logic              strap_valid_o,
  output logic              bootstrap_o
);

  import chip_io_pkg::*;

  ////////////////////
  // Input conditioning
  ////////////////////

  mio_t mio_sync;  // Filtered MIO levels
  dio_t dio_sync;  // Filtered DIO levels

  pad_sync #(
    .data_t ( mio_t )
  ) u_mio_sync (
    .clk_i   ( clk_i        ),
    .rst_n_i ( rst_n_i      ),
    .pad_i   ( mio_pad_in_i ),
    .sync_o  ( mio_sync     )
  );

  pad_sync #(
    .data_t ( dio_t )
  ) u_dio_sync (
    .clk_i   ( clk_i        ),
    .rst_n_i ( rst_n_i      ),
    .pad_i   ( dio_pad_in_i ),
    .sync_o  ( dio_sync     )
  );

  ////////////////////
  // JTAG overlay mux
  ////////////////////

  jtag_overlay u_jtag_overlay (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    // From synchronizers
    .mio_sync_i     ( mio_sync       ),
    .dio_sync_i     ( dio_sync       ),
    // Core side
    .mio_out_core_i ( mio_out_core_i ),
    .mio_oe_core_i  ( mio_oe_core_i  ),
    .dio_out_core_i ( dio_out_core_i ),
    .dio_oe_core_i  ( dio_oe_core_i  ),
    .mio_in_core_o  ( mio_in_core_o  ),
    .dio_in_core_o  ( dio_in_core_o  ),
    // Pad side
    .mio_pad_out_o  ( mio_pad_out_o  ),
    .mio_pad_oe_o   ( mio_pad_oe_o   ),
    .dio_pad_out_o  ( dio_pad_out_o  ),
    .dio_pad_oe_o   ( dio_pad_oe_o   ),
    // JTAG
    .jtag_tck_o     ( jtag_tck_o     ),
    .jtag_tms_o     ( jtag_tms_o     ),
    .jtag_tdi_o     ( jtag_tdi_o     ),
    .jtag_trst_no   ( jtag_trst_no   ),
    .jtag_srst_no   ( jtag_srst_no   ),
    .jtag_tdo_i     ( jtag_tdo_i     ),
    // Straps
    .strap_valid_o  ( strap_valid_o  ),
    .bootstrap_o    ( bootstrap_o    )
  );

endmodule : chip_io_top

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
////////////////////
// Testbench clock and reset source
////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  input  logic rst_req_i,  // Rising edge starts a fresh reset
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HalfPeriod  = 20;  // 40 ns clock
  localparam int ResetCycles = 5;

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

  // Reset asserts at once and releases on a falling edge
  initial begin
    rst_n_o = 1'b0;
    forever begin
      repeat (ResetCycles) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
      @(posedge rst_req_i);
      rst_n_o = 1'b0;
    end
  end

endmodule : tb_clock_gen

`default_nettype wire

// ==== bench/chip_io_assertions.sv ====
////////////////////
// Overlay assertions, bound into jtag_overlay
////////////////////
`timescale 1ns/10ps
`default_nettype none

module chip_io_assertions (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              strap_valid_i,
  input logic              jtag_en_i,
  input logic              jtag_trst_n_i,
  input chip_io_pkg::dio_t dio_in_core_i,
  input chip_io_pkg::dio_t dio_pad_oe_i
);

  import chip_io_pkg::*;

  // TAP stays in reset until the straps are known
  trst_held_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !strap_valid_i |-> !jtag_trst_n_i
  ) else $error("jtag_trst_no released before the straps were latched");

  csb_idle_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) jtag_en_i |-> dio_in_core_i[DioCsbIdx]
  ) else $error("core saw CSB low in JTAG mode");

  sdo_driven_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) jtag_en_i |-> dio_pad_oe_i[DioSdoIdx]
  ) else $error("SDO pad not driven in JTAG mode");

endmodule : chip_io_assertions

bind jtag_overlay chip_io_assertions u_assertions (
  .clk_i         ( clk_i         ),
  .rst_n_i       ( rst_n_i       ),
  .strap_valid_i ( strap_valid_o ),
  .jtag_en_i     ( jtag_en_q     ),
  .jtag_trst_n_i ( jtag_trst_no  ),
  .dio_in_core_i ( dio_in_core_o ),
  .dio_pad_oe_i  ( dio_pad_oe_o  )
);

`default_nettype wire

// ==== bench/chip_io_tb.sv ====
////////////////////
// Directed tests for chip_io_top, compare
// tasks and a cycle timeout
////////////////////
`timescale 1ns/10ps
`default_nettype none

module chip_io_tb;

  import chip_io_pkg::*;

  localparam int TimeoutCycles = 600;  // Tests run about 280 cycles
  localparam int GlitchWatch   = 6;    // Cycles watched after a glitch

  logic   clk;
  logic   rst_n;
  logic   rst_req;
  mio_t   mio_pad_in, mio_out_core, mio_oe_core;
  dio_t   dio_pad_in, dio_out_core, dio_oe_core;
  logic   jtag_tdo;
  mio_t   mio_pad_out, mio_pad_oe, mio_in_core;
  dio_t   dio_pad_out, dio_pad_oe, dio_in_core;
  logic   jtag_tck, jtag_tms, jtag_tdi, jtag_trst_n, jtag_srst_n;
  logic   strap_valid, bootstrap;
  integer seed      = 32'hc467c956;
  int     cycle_cnt = 0;

  tb_clock_gen clock_gen_inst (.rst_req_i(rst_req), .clk_o(clk), .rst_n_o(rst_n));

  chip_io_top chip_io_top_inst (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .mio_pad_in_i   ( mio_pad_in   ),
    .dio_pad_in_i   ( dio_pad_in   ),
    .mio_pad_out_o  ( mio_pad_out  ),
    .mio_pad_oe_o   ( mio_pad_oe   ),
    .dio_pad_out_o  ( dio_pad_out  ),
    .dio_pad_oe_o   ( dio_pad_oe   ),
    .mio_out_core_i ( mio_out_core ),
    .mio_oe_core_i  ( mio_oe_core  ),
    .dio_out_core_i ( dio_out_core ),
    .dio_oe_core_i  ( dio_oe_core  ),
    .mio_in_core_o  ( mio_in_core  ),
    .dio_in_core_o  ( dio_in_core  ),
    .jtag_tck_o     ( jtag_tck     ),
    .jtag_tms_o     ( jtag_tms     ),
    .jtag_tdi_o     ( jtag_tdi     ),
    .jtag_trst_no   ( jtag_trst_n  ),
    .jtag_srst_no   ( jtag_srst_n  ),
    .jtag_tdo_i     ( jtag_tdo     ),
    .strap_valid_o  ( strap_valid  ),
    .bootstrap_o    ( bootstrap    )
  );

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_mio(input string name, input mio_t actual, input mio_t expected);
    if (actual !== expected) begin
      report_failure($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic check_dio(input string name, input dio_t actual, input dio_t expected);
    if (actual !== expected) begin
      report_failure($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      report_failure($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  // Core view and JTAG outputs for the given settled pad levels
  task automatic check_core_side(input mio_t mio_pad, input dio_t dio_pad, input logic jtag);
    mio_t mio_exp;
    dio_t dio_exp;
    mio_exp = mio_pad;
    dio_exp = dio_pad;
    if (jtag) begin
      mio_exp[MioTrstIdx] = MioTieOff[MioTrstIdx];
      mio_exp[MioSrstIdx] = MioTieOff[MioSrstIdx];
      dio_exp[DioSckIdx]  = DioTieOff[DioSckIdx];
      dio_exp[DioCsbIdx]  = DioTieOff[DioCsbIdx];
      dio_exp[DioSdiIdx]  = DioTieOff[DioSdiIdx];
      dio_exp[DioSdoIdx]  = DioTieOff[DioSdoIdx];
    end
    check_mio("mio_in_core_o", mio_in_core, mio_exp);
    check_dio("dio_in_core_o", dio_in_core, dio_exp);
    check_bit("jtag_tck_o", jtag_tck, jtag ? dio_pad[DioSckIdx] : 1'b0);
    check_bit("jtag_tms_o", jtag_tms, jtag ? dio_pad[DioCsbIdx] : 1'b0);
    check_bit("jtag_tdi_o", jtag_tdi, jtag ? dio_pad[DioSdiIdx] : 1'b0);
    check_bit("jtag_trst_no", jtag_trst_n, jtag ? mio_pad[MioTrstIdx] : 1'b0);
    check_bit("jtag_srst_no", jtag_srst_n, jtag ? mio_pad[MioSrstIdx] : 1'b1);
  endtask

  // Pad drivers against the core values currently applied
  task automatic check_pad_side(input logic jtag);
    mio_t mio_oe_exp;
    dio_t dio_out_exp;
    dio_t dio_oe_exp;
    mio_oe_exp  = mio_oe_core;
    dio_out_exp = dio_out_core;
    dio_oe_exp  = dio_oe_core;
    if (jtag) begin
      mio_oe_exp[MioTrstIdx] = 1'b0;
      mio_oe_exp[MioSrstIdx] = 1'b0;
      dio_oe_exp[DioSckIdx]  = 1'b0;
      dio_oe_exp[DioCsbIdx]  = 1'b0;
      dio_oe_exp[DioSdiIdx]  = 1'b0;
      dio_out_exp[DioSdoIdx] = jtag_tdo;  // TDO owns the SDO pad
      dio_oe_exp[DioSdoIdx]  = 1'b1;
    end
    check_mio("mio_pad_out_o", mio_pad_out, mio_out_core);
    check_mio("mio_pad_oe_o", mio_pad_oe, mio_oe_exp);
    check_dio("dio_pad_out_o", dio_pad_out, dio_out_exp);
    check_dio("dio_pad_oe_o", dio_pad_oe, dio_oe_exp);
  endtask

  ////////////////////
  // Stimulus helpers
  ////////////////////

  task automatic drive_core_random();
    mio_out_core = mio_t'($random(seed));
    mio_oe_core  = mio_t'($random(seed));
    dio_out_core = dio_t'($random(seed));
    dio_oe_core  = dio_t'($random(seed));
    jtag_tdo     = 1'($random(seed));
  endtask

  task automatic drive_pads_random();
    mio_pad_in = mio_t'($random(seed));
    dio_pad_in = dio_t'($random(seed));
  endtask

  // Mux path is combinational, wait a quarter period
  task automatic settle_comb();
    #10;
  endtask

  task automatic apply_reset(input mio_t straps);
    @(negedge clk);
    mio_pad_in = straps;
    dio_pad_in = '0;
    rst_req    = 1'b1;
    wait (rst_n === 1'b0);
    rst_req    = 1'b0;
    @(posedge rst_n);
  endtask

  task automatic wait_straps();
    int waited;
    waited = 0;
    while (!strap_valid) begin
      @(negedge clk);
      waited++;
      if (waited > 2 * StrapDelay) begin
        report_failure("strap_valid_o did not rise after reset release");
      end
    end
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset_straps();
    @(posedge rst_n);
    repeat (StrapDelay) begin
      check_bit("strap_valid_o", strap_valid, 1'b0);
      check_bit("bootstrap_o", bootstrap, 1'b0);
      check_bit("jtag_trst_no", jtag_trst_n, 1'b0);
      check_bit("jtag_srst_no", jtag_srst_n, 1'b1);
      check_bit("jtag_tck_o", jtag_tck, 1'b0);
      @(negedge clk);
    end
    wait_straps();
    check_bit("strap_valid_o", strap_valid, 1'b1);
    check_bit("bootstrap_o", bootstrap, mio_pad_in[MioBootstrapIdx]);
  endtask

  task automatic test_passthrough();
    mio_t mio_prev;
    dio_t dio_prev;
    repeat (16) begin
      @(negedge clk);
      drive_core_random();
      settle_comb();
      check_pad_side(1'b0);
    end
    repeat (12) begin
      @(negedge clk);
      mio_prev = mio_pad_in;
      dio_prev = dio_pad_in;
      drive_pads_random();
      repeat (SyncLatency - 1) @(negedge clk);
      check_core_side(mio_prev, dio_prev, 1'b0);  // Still behind the filter
      @(negedge clk);
      check_core_side(mio_pad_in, dio_pad_in, 1'b0);
    end
  endtask

  task automatic test_glitch();
    mio_t mio_base;
    dio_t dio_base;
    mio_t mio_flip;
    dio_t dio_flip;
    repeat (4) begin
      @(negedge clk);
      drive_pads_random();
      mio_base = mio_pad_in;
      dio_base = dio_pad_in;
      repeat (SyncLatency) @(negedge clk);
      mio_flip = mio_t'($random(seed));
      dio_flip = dio_t'($random(seed));
      if (mio_flip == '0) mio_flip = mio_t'(1);
      if (dio_flip == '0) dio_flip = dio_t'(1);
      mio_pad_in = mio_base ^ mio_flip;  // One cycle pulse
      dio_pad_in = dio_base ^ dio_flip;
      @(negedge clk);
      mio_pad_in = mio_base;
      dio_pad_in = dio_base;
      repeat (GlitchWatch) begin
        @(negedge clk);
        check_core_side(mio_base, dio_base, 1'b0);
      end
    end
  endtask

  task automatic test_jtag_mode();
    apply_reset(mio_t'(1) << MioJtagEnIdx);  // Bootstrap low this time
    wait_straps();
    check_bit("strap_valid_o", strap_valid, 1'b1);
    check_bit("bootstrap_o", bootstrap, 1'b0);
    check_core_side(mio_pad_in, dio_pad_in, 1'b1);
    repeat (12) begin
      @(negedge clk);
      jtag_tdo = 1'($random(seed));
      drive_pads_random();
      settle_comb();
      check_pad_side(1'b1);
      repeat (SyncLatency) @(negedge clk);
      check_core_side(mio_pad_in, dio_pad_in, 1'b1);
    end
  endtask

  task automatic test_jtag_other_pins();
    repeat (12) begin
      @(negedge clk);
      drive_core_random();
      drive_pads_random();
      settle_comb();
      check_pad_side(1'b1);
      repeat (SyncLatency) @(negedge clk);
      check_core_side(mio_pad_in, dio_pad_in, 1'b1);
    end
    // Strap pin held high, then dropped after the latch
    @(negedge clk);
    mio_pad_in[MioJtagEnIdx] = 1'b1;
    repeat (SyncLatency) @(negedge clk);
    check_core_side(mio_pad_in, dio_pad_in, 1'b1);
    mio_pad_in[MioJtagEnIdx] = 1'b0;
    repeat (SyncLatency + 2) begin
      @(negedge clk);
      check_bit("strap_valid_o", strap_valid, 1'b1);
      check_pad_side(1'b1);
    end
    check_core_side(mio_pad_in, dio_pad_in, 1'b1);
  endtask

  ////////////////////
  // Timeout and sequence
  ////////////////////

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      report_failure("Timeout: the tests did not finish within the cycle limit");
    end
  end

  initial begin
    rst_req      = 1'b0;
    mio_pad_in   = mio_t'(1) << MioBootstrapIdx;  // JTAG strap low, bootstrap high
    dio_pad_in   = '0;
    mio_out_core = '0;
    mio_oe_core  = '0;
    dio_out_core = '0;
    dio_oe_core  = '0;
    jtag_tdo     = 1'b0;
    test_reset_straps();
    test_passthrough();
    test_glitch();
    test_jtag_mode();
    test_jtag_other_pins();
    $display("all tests passed");
    $finish;
  end

endmodule : chip_io_tb

`default_nettype wire

// ==== files.f ====
rtl/chip_io_pkg.sv
rtl/pad_sync.sv
rtl/jtag_overlay.sv
rtl/chip_io_top.sv
bench/tb_clock_gen.sv
bench/chip_io_assertions.sv
bench/chip_io_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the chip_io testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module chip_io_tb \
  -f files.f -o chip_io_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/chip_io_sim > "$LOG" 2>&1
cat "$LOG"

grep -qx "all tests passed" "$LOG" && echo "Simulation passed" \
  || { echo "Simulation failed, see $LOG"; exit 1; }
